//--- mrp_pkg.sv
package mrp_pkg;

    // Head pointer source at the start of a fragment
    typedef enum logic {
        MEM   = 1'b0,   // Value read from the pointer table
        RESET = 1'b1    // Offset zero, first fragment of a message
    } rx_ptr_mux_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter int DATA_W_DEF     = 32;
    parameter int CONN_W_DEF     = 2;   // Four connections
    parameter int SLOT_W_DEF     = 4;   // 16 words per slot
    parameter int FIFO_DEPTH_DEF = 4;

endpackage

//--- mrp_rx_buffer_input_ctrl.sv
`timescale 1ns/100ps
module mrp_rx_buffer_input_ctrl (
     input                                  clk
    ,input                                  rst

    ,input                                  meta_val
    ,input                                  meta_start
    ,input                                  meta_msg_done
    ,output logic                           meta_rdy

    ,input                                  data_val
    ,input                                  data_last
    ,output logic                           data_rdy

    ,output logic                           buf_wr_req
    ,output logic                           ptr_rd_req
    ,output logic                           ptr_wr_req

    ,output logic                           store_meta
    ,output logic                           store_rx_ptrs
    ,output mrp_pkg::rx_ptr_mux_sel_e       rx_ptrs_sel
    ,output logic                           incr_head_ptr
    ,input                                  ptrs_stored

    ,output logic                           enq_req
    ,input                                  enq_rdy
);

    typedef enum logic [1:0] {
        READY      = 2'd0,
        WR_PAYLOAD = 2'd1,
        ENQ_OUTPUT = 2'd2
    } state_e;

    state_e state_reg;
    state_e state_next;

    logic   start_reg;
    logic   done_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and fragment flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
            start_reg <= 1'b0;
            done_reg  <= 1'b0;
        end
        else begin
            state_reg <= state_next;
            if (store_meta) begin
                start_reg <= meta_start;
                done_reg  <= meta_msg_done;
            end
        end
    end

    always_comb begin
        meta_rdy      = 1'b0;
        data_rdy      = 1'b0;
        buf_wr_req    = 1'b0;
        ptr_rd_req    = 1'b0;
        ptr_wr_req    = 1'b0;
        store_meta    = 1'b0;
        store_rx_ptrs = 1'b0;
        rx_ptrs_sel   = mrp_pkg::MEM;
        incr_head_ptr = 1'b0;
        enq_req       = 1'b0;
        state_next    = state_reg;

        case (state_reg)
            READY: begin
                meta_rdy = 1'b1;
                if (meta_val) begin
                    store_meta = 1'b1;
                    ptr_rd_req = ~meta_start;   // Continuation needs the stored head
                    state_next = WR_PAYLOAD;
                end
            end
            WR_PAYLOAD: begin
                data_rdy      = 1'b1;
                store_rx_ptrs = ~ptrs_stored;   // Only in the first payload cycle
                rx_ptrs_sel   = start_reg ? mrp_pkg::RESET : mrp_pkg::MEM;
                if (data_val) begin
                    buf_wr_req    = 1'b1;
                    incr_head_ptr = 1'b1;
                    if (data_last) begin
                        ptr_wr_req = 1'b1;      // Save head for the next fragment
                        state_next = done_reg ? ENQ_OUTPUT : READY;
                    end
                end
            end
            ENQ_OUTPUT: begin
                enq_req = 1'b1;
                if (enq_rdy) begin
                    state_next = READY;
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

endmodule

//--- mrp_rx_buffer_input_datap.sv
`timescale 1ns/100ps
module mrp_rx_buffer_input_datap #(
     parameter int DATA_W = mrp_pkg::DATA_W_DEF
    ,parameter int CONN_W = mrp_pkg::CONN_W_DEF
    ,parameter int SLOT_W = mrp_pkg::SLOT_W_DEF
) (
     input                                  clk
    ,input                                  rst

    ,input          [CONN_W-1:0]            meta_conn_id
    ,input          [DATA_W-1:0]            data

    ,input                                  store_meta
    ,input                                  store_rx_ptrs
    ,input  mrp_pkg::rx_ptr_mux_sel_e       rx_ptrs_sel
    ,input                                  incr_head_ptr
    ,output logic                           ptrs_stored

    ,input          [SLOT_W-1:0]            ptr_rd_data

    ,output logic   [CONN_W-1:0]            conn_id
    ,output logic   [SLOT_W-1:0]            next_head
    ,output logic   [CONN_W+SLOT_W-1:0]     wr_addr
    ,output logic   [DATA_W-1:0]            wr_data
);

    logic [CONN_W-1:0] conn_id_reg;
    logic [SLOT_W-1:0] head_reg;
    logic [SLOT_W-1:0] ptr_mux;
    logic [SLOT_W-1:0] cur_head;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptrs_stored <= 1'b0;
        end
        else if (store_meta) begin
            ptrs_stored <= 1'b0;
        end
        else if (store_rx_ptrs) begin
            ptrs_stored <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_meta) begin
            conn_id_reg <= meta_conn_id;
        end
        head_reg <= next_head;              // Holds when idle since incr is low
    end

    assign ptr_mux   = (rx_ptrs_sel == mrp_pkg::RESET) ? '0 : ptr_rd_data;
    assign cur_head  = store_rx_ptrs ? ptr_mux : head_reg;
    assign next_head = cur_head + SLOT_W'(incr_head_ptr);

    // Bypass so the table read sees the id in the accept cycle
    assign conn_id = store_meta ? meta_conn_id : conn_id_reg;

    assign wr_addr = {conn_id_reg, cur_head};   // Slot base plus head
    assign wr_data = data;

endmodule

//--- mrp_rx_ptr_table.sv
`timescale 1ns/100ps
module mrp_rx_ptr_table #(
     parameter int CONN_W = mrp_pkg::CONN_W_DEF
    ,parameter int SLOT_W = mrp_pkg::SLOT_W_DEF
) (
     input                          clk
    ,input                          rst

    ,input                          rd_req
    ,input                          wr_req
    ,input          [CONN_W-1:0]    conn_id
    ,input          [SLOT_W-1:0]    wr_head
    ,output logic   [SLOT_W-1:0]    rd_head
);

    localparam int NUM_CONN = 2 ** CONN_W;

    logic [SLOT_W-1:0] heads [NUM_CONN];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CONN; i++) begin
                heads[i] <= '0;
            end
        end
        else if (wr_req) begin
            heads[conn_id] <= wr_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_head <= heads[conn_id];
        end
    end

endmodule

//--- mrp_rx_buffer_ram.sv
`timescale 1ns/100ps
module mrp_rx_buffer_ram #(
     parameter int DATA_W = mrp_pkg::DATA_W_DEF
    ,parameter int ADDR_W = mrp_pkg::CONN_W_DEF + mrp_pkg::SLOT_W_DEF
) (
     input                          clk

    ,input                          wr_en
    ,input          [ADDR_W-1:0]    wr_addr
    ,input          [DATA_W-1:0]    wr_data

    ,input          [ADDR_W-1:0]    rd_addr
    ,output logic   [DATA_W-1:0]    rd_data
);

    localparam int NUM_WORDS = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [NUM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- mrp_msg_desc_fifo.sv
`timescale 1ns/100ps
module mrp_msg_desc_fifo #(
     parameter int CONN_W = mrp_pkg::CONN_W_DEF
    ,parameter int SLOT_W = mrp_pkg::SLOT_W_DEF
    ,parameter int DEPTH  = mrp_pkg::FIFO_DEPTH_DEF
) (
     input                          clk
    ,input                          rst

    ,input                          enq_req
    ,input          [CONN_W-1:0]    enq_conn_id
    ,input          [SLOT_W-1:0]    enq_len
    ,output logic                   enq_rdy

    ,output logic                   deq_val
    ,output logic   [CONN_W-1:0]    deq_conn_id
    ,output logic   [SLOT_W-1:0]    deq_len
    ,input                          deq_rdy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CONN_W-1:0] conn_mem [DEPTH];
    logic [SLOT_W-1:0] len_mem  [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_enq;
    logic              do_deq;

    assign enq_rdy = (count != CNT_W'(DEPTH));  // Not full
    assign deq_val = (count != '0);             // Not empty
    assign do_enq  = enq_req & enq_rdy;
    assign do_deq  = deq_val & deq_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            conn_mem[wr_ptr] <= enq_conn_id;
            len_mem[wr_ptr]  <= enq_len;
        end
    end

    assign deq_conn_id = conn_mem[rd_ptr];
    assign deq_len     = len_mem[rd_ptr];

endmodule

//--- mrp_rx_buffer.sv
`timescale 1ns/100ps
module mrp_rx_buffer #(
     parameter int DATA_W     = mrp_pkg::DATA_W_DEF
    ,parameter int CONN_W     = mrp_pkg::CONN_W_DEF
    ,parameter int SLOT_W     = mrp_pkg::SLOT_W_DEF
    ,parameter int FIFO_DEPTH = mrp_pkg::FIFO_DEPTH_DEF
) (
     input                                  clk
    ,input                                  rst

    ,input                                  meta_val
    ,input          [CONN_W-1:0]            meta_conn_id
    ,input                                  meta_start
    ,input                                  meta_msg_done
    ,output logic                           meta_rdy

    ,input                                  data_val
    ,input          [DATA_W-1:0]            data
    ,input                                  data_last
    ,output logic                           data_rdy

    ,output logic                           desc_val
    ,output logic   [CONN_W-1:0]            desc_conn_id
    ,output logic   [SLOT_W-1:0]            desc_len
    ,input                                  desc_rdy

    ,input          [CONN_W+SLOT_W-1:0]     rd_addr
    ,output logic   [DATA_W-1:0]            rd_data
);

    localparam int ADDR_W = CONN_W + SLOT_W;

    logic                       buf_wr_req;
    logic                       ptr_rd_req;
    logic                       ptr_wr_req;
    logic                       store_meta;
    logic                       store_rx_ptrs;
    mrp_pkg::rx_ptr_mux_sel_e   rx_ptrs_sel;
    logic                       incr_head_ptr;
    logic                       ptrs_stored;
    logic                       enq_req;
    logic                       enq_rdy;

    logic [CONN_W-1:0]          conn_id;
    logic [SLOT_W-1:0]          next_head;
    logic [SLOT_W-1:0]          ptr_rd_data;
    logic [ADDR_W-1:0]          wr_addr;
    logic [DATA_W-1:0]          wr_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fragment control and datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mrp_rx_buffer_input_ctrl input_ctrl_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.meta_val      (meta_val)
        ,.meta_start    (meta_start)
        ,.meta_msg_done (meta_msg_done)
        ,.meta_rdy      (meta_rdy)
        ,.data_val      (data_val)
        ,.data_last     (data_last)
        ,.data_rdy      (data_rdy)
        ,.buf_wr_req    (buf_wr_req)
        ,.ptr_rd_req    (ptr_rd_req)
        ,.ptr_wr_req    (ptr_wr_req)
        ,.store_meta    (store_meta)
        ,.store_rx_ptrs (store_rx_ptrs)
        ,.rx_ptrs_sel   (rx_ptrs_sel)
        ,.incr_head_ptr (incr_head_ptr)
        ,.ptrs_stored   (ptrs_stored)
        ,.enq_req       (enq_req)
        ,.enq_rdy       (enq_rdy)
    );

    mrp_rx_buffer_input_datap #(
         .DATA_W    (DATA_W)
        ,.CONN_W    (CONN_W)
        ,.SLOT_W    (SLOT_W)
    ) input_datap_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.meta_conn_id  (meta_conn_id)
        ,.data          (data)
        ,.store_meta    (store_meta)
        ,.store_rx_ptrs (store_rx_ptrs)
        ,.rx_ptrs_sel   (rx_ptrs_sel)
        ,.incr_head_ptr (incr_head_ptr)
        ,.ptrs_stored   (ptrs_stored)
        ,.ptr_rd_data   (ptr_rd_data)
        ,.conn_id       (conn_id)
        ,.next_head     (next_head)
        ,.wr_addr       (wr_addr)
        ,.wr_data       (wr_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mrp_rx_ptr_table #(
         .CONN_W    (CONN_W)
        ,.SLOT_W    (SLOT_W)
    ) ptr_table_inst (
         .clk       (clk)
        ,.rst       (rst)
        ,.rd_req    (ptr_rd_req)
        ,.wr_req    (ptr_wr_req)
        ,.conn_id   (conn_id)
        ,.wr_head   (next_head)
        ,.rd_head   (ptr_rd_data)
    );

    mrp_rx_buffer_ram #(
         .DATA_W    (DATA_W)
        ,.ADDR_W    (ADDR_W)
    ) buffer_ram_inst (
         .clk       (clk)
        ,.wr_en     (buf_wr_req)
        ,.wr_addr   (wr_addr)
        ,.wr_data   (wr_data)
        ,.rd_addr   (rd_addr)
        ,.rd_data   (rd_data)
    );

    mrp_msg_desc_fifo #(
         .CONN_W    (CONN_W)
        ,.SLOT_W    (SLOT_W)
        ,.DEPTH     (FIFO_DEPTH)
    ) desc_fifo_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.enq_req       (enq_req)
        ,.enq_conn_id   (conn_id)
        ,.enq_len       (next_head)     // Head after the last beat is the length
        ,.enq_rdy       (enq_rdy)
        ,.deq_val       (desc_val)
        ,.deq_conn_id   (desc_conn_id)
        ,.deq_len       (desc_len)
        ,.deq_rdy       (desc_rdy)
    );

endmodule

//--- tb_mrp_rx_buffer_assert.sv
`timescale 1ns/100ps
module mrp_rx_buffer_input_ctrl_assert (
     input  clk
    ,input  rst
    ,input  meta_rdy
    ,input  data_rdy
    ,input  data_val
    ,input  buf_wr_req
    ,input  enq_req
    ,input  enq_rdy
);

    // Metadata and payload phases never overlap
    rdy_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(meta_rdy && data_rdy))
        else $error("meta_rdy and data_rdy are high together");

    wr_needs_data: assert property (@(posedge clk) disable iff (rst)
        buf_wr_req |-> data_val)
        else $error("buf_wr_req is high without data_val");

    enq_held: assert property (@(posedge clk) disable iff (rst)
        (enq_req && !enq_rdy) |=> enq_req)
        else $error("enq_req dropped before enq_rdy");

endmodule

bind mrp_rx_buffer_input_ctrl mrp_rx_buffer_input_ctrl_assert ctrl_assert_inst (
     .clk        (clk)
    ,.rst        (rst)
    ,.meta_rdy   (meta_rdy)
    ,.data_rdy   (data_rdy)
    ,.data_val   (data_val)
    ,.buf_wr_req (buf_wr_req)
    ,.enq_req    (enq_req)
    ,.enq_rdy    (enq_rdy)
);

//--- tb_mrp_rx_buffer.sv
`timescale 1ns/100ps
module tb_mrp_rx_buffer;

    localparam int DATA_W      = mrp_pkg::DATA_W_DEF;
    localparam int CONN_W      = mrp_pkg::CONN_W_DEF;
    localparam int SLOT_W      = mrp_pkg::SLOT_W_DEF;
    localparam int FIFO_DEPTH  = mrp_pkg::FIFO_DEPTH_DEF;
    localparam int NUM_CONN    = 2 ** CONN_W;
    localparam int SLOT_WORDS  = 2 ** SLOT_W;
    localparam int CLK_PERIOD  = 10;
    localparam int TOTAL_BEATS = 45;    // Data beats sent over all tests
    localparam int BEAT_MARGIN = 20;    // Cycles per beat, covers gaps and reads
    localparam int TIMEOUT_NS  = TOTAL_BEATS * BEAT_MARGIN * CLK_PERIOD;

    logic                       clk;
    logic                       rst;
    logic                       meta_val;
    logic [CONN_W-1:0]          meta_conn_id;
    logic                       meta_start;
    logic                       meta_msg_done;
    logic                       meta_rdy;
    logic                       data_val;
    logic [DATA_W-1:0]          data;
    logic                       data_last;
    logic                       data_rdy;
    logic                       desc_val;
    logic [CONN_W-1:0]          desc_conn_id;
    logic [SLOT_W-1:0]          desc_len;
    logic                       desc_rdy;
    logic [CONN_W+SLOT_W-1:0]   rd_addr;
    logic [DATA_W-1:0]          rd_data;

    integer                     seed;
    logic [DATA_W-1:0]          model_mem [NUM_CONN][SLOT_WORDS];
    int                         model_len [NUM_CONN];
    int                         exp_conn_q [$];
    int                         exp_len_q [$];

    mrp_rx_buffer #(
         .DATA_W        (DATA_W)
        ,.CONN_W        (CONN_W)
        ,.SLOT_W        (SLOT_W)
        ,.FIFO_DEPTH    (FIFO_DEPTH)
    ) mrp_rx_buffer_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.meta_val      (meta_val)
        ,.meta_conn_id  (meta_conn_id)
        ,.meta_start    (meta_start)
        ,.meta_msg_done (meta_msg_done)
        ,.meta_rdy      (meta_rdy)
        ,.data_val      (data_val)
        ,.data          (data)
        ,.data_last     (data_last)
        ,.data_rdy      (data_rdy)
        ,.desc_val      (desc_val)
        ,.desc_conn_id  (desc_conn_id)
        ,.desc_len      (desc_len)
        ,.desc_rdy      (desc_rdy)
        ,.rd_addr       (rd_addr)
        ,.rd_data       (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display(">>> FAIL");
        $fatal(1, "Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Check and driver tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Stopped on first error");
        end
    endtask

    task automatic send_fragment(input int conn, input bit start, input bit done,
                                 input int beats, input int max_gap);
        logic [DATA_W-1:0] word;
        int                gap;
        @(negedge clk);
        meta_val      = 1'b1;
        meta_conn_id  = CONN_W'(conn);
        meta_start    = start;
        meta_msg_done = done;
        while (!meta_rdy) @(negedge clk);
        @(negedge clk);
        meta_val = 1'b0;
        if (start) begin
            model_len[conn] = 0;
        end
        for (int i = 0; i < beats; i++) begin
            gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
            repeat (gap) @(negedge clk);        // Idle with data_val low
            word      = $random(seed);
            data_val  = 1'b1;
            data      = word;
            data_last = (i == beats - 1);
            while (!data_rdy) @(negedge clk);
            model_mem[conn][model_len[conn] % SLOT_WORDS] = word;
            model_len[conn]++;
            @(negedge clk);
            data_val  = 1'b0;
            data_last = 1'b0;
        end
        if (done) begin
            exp_conn_q.push_back(conn);
            exp_len_q.push_back(model_len[conn] % SLOT_WORDS);
        end
    endtask

    task automatic pop_desc();
        int conn;
        int len;
        while (!desc_val) @(negedge clk);
        conn = exp_conn_q.pop_front();
        len  = exp_len_q.pop_front();
        check_value("desc_conn_id", 32'(desc_conn_id), 32'(conn));
        check_value("desc_len", 32'(desc_len), 32'(len));
        desc_rdy = 1'b1;
        @(negedge clk);
        desc_rdy = 1'b0;
    endtask

    task automatic check_slot(input int conn);
        for (int i = 0; i < model_len[conn]; i++) begin
            @(negedge clk);
            rd_addr = {CONN_W'(conn), SLOT_W'(i)};
            @(negedge clk);                     // One cycle read latency
            check_value("rd_data", 32'(rd_data), 32'(model_mem[conn][i]));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_single_message();
        send_fragment(3, 1'b1, 1'b1, 5, 0);
        pop_desc();
        check_slot(3);
    endtask

    task automatic test_interleaved();
        send_fragment(1, 1'b1, 1'b0, 3, 0);     // Opens message on connection 1
        send_fragment(2, 1'b1, 1'b1, 4, 0);
        send_fragment(1, 1'b0, 1'b1, 5, 0);
        pop_desc();
        pop_desc();
        check_slot(2);
        check_slot(1);
    endtask

    task automatic test_data_gaps();
        send_fragment(0, 1'b1, 1'b0, 6, 3);
        send_fragment(0, 1'b0, 1'b1, 4, 3);
        pop_desc();
        check_slot(0);
    endtask

    task automatic test_restart();
        send_fragment(2, 1'b1, 1'b1, 3, 0);     // Slot 2 held 4 words before
        pop_desc();
        check_slot(2);
    endtask

    task automatic test_back_pressure();
        for (int k = 0; k <= FIFO_DEPTH; k++) begin
            send_fragment(k % NUM_CONN, 1'b1, 1'b1, 3, 0);
        end
        repeat (2) @(negedge clk);
        check_value("meta_rdy", 32'(meta_rdy), 32'd0);
        check_value("desc_val", 32'(desc_val), 32'd1);
        for (int k = 0; k <= FIFO_DEPTH; k++) begin
            pop_desc();
        end
        for (int c = 0; c < NUM_CONN; c++) begin
            check_slot(c);
        end
    endtask

    initial begin
        seed          = 32'h1f72d521;
        rst           = 1'b1;
        meta_val      = 1'b0;
        meta_conn_id  = '0;
        meta_start    = 1'b0;
        meta_msg_done = 1'b0;
        data_val      = 1'b0;
        data          = '0;
        data_last     = 1'b0;
        desc_rdy      = 1'b0;
        rd_addr       = '0;
        for (int c = 0; c < NUM_CONN; c++) begin
            model_len[c] = 0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_value("meta_rdy", 32'(meta_rdy), 32'd1);
        check_value("data_rdy", 32'(data_rdy), 32'd0);
        check_value("desc_val", 32'(desc_val), 32'd0);

        test_single_message();
        test_interleaved();
        test_data_gaps();
        test_restart();
        test_back_pressure();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- list.f
mrp_pkg.sv
mrp_rx_buffer_input_ctrl.sv
mrp_rx_buffer_input_datap.sv
mrp_rx_ptr_table.sv
mrp_rx_buffer_ram.sv
mrp_msg_desc_fifo.sv
mrp_rx_buffer.sv
tb_mrp_rx_buffer_assert.sv
tb_mrp_rx_buffer.sv

//--- Makefile
# Verilator build and run of the receive buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_mrp_rx_buffer
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
